// File: src/rv_consts.svh
// Widths, reset PC and major opcode encodings of the RV32I front end
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN         32
`define RV_ILEN         32
`define RV_RESET_PC     32'h0000_0000

// RV32I major opcodes
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_FENCE     7'b0001111
`define RV_OP_SYSTEM    7'b1110011

`endif

// File: src/rv_pkg.sv
// Instruction format union, decoded record and issue record types
`include "rv_consts.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0]  funct7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [6:0]  imm_11_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_4_0;
        logic [6:0]  opcode;
    } rv_s_fmt_t;

    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        logic [6:0]  opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_j_fmt_t;

    // One fetched word, read in whichever layout its opcode calls for
    typedef union packed {
        logic [`RV_ILEN-1:0] raw;
        rv_r_fmt_t           r;
        rv_i_fmt_t           i;
        rv_s_fmt_t           s;
        rv_b_fmt_t           b;
        rv_u_fmt_t           u;
        rv_j_fmt_t           j;
    } rv_instr_u;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [4:0]  zimm;
        logic [11:0] csr;
        logic [5:0]  shamt;
        logic [3:0]  pred;
        logic [3:0]  succ;
        logic [11:0] imm12;
        logic [19:0] imm20;
        // bit 0 fence, bit 1 fence.i
        logic [1:0]  fence;
        // ecall, ebreak, CSR from bit 0 up
        logic [2:0]  env;
        logic        lui;
        logic        auipc;
        logic        jal;
        logic        jalr;
        logic        branching;
        logic        processing;
        logic        inst_error;
    } rv_dec_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        rv_dec_t             dec;
    } rv_issue_t;

endpackage

// File: src/rv_decoder.sv
// Combinational RV32I decoder from instruction word to decoded record
`include "rv_consts.svh"

module rv_decoder (
    input  rv_pkg::rv_instr_u instruction,
    output rv_pkg::rv_dec_t   dec
);

    always_comb begin
        // Plain field slices valid whatever the format
        dec.opcode = instruction.r.opcode;
        dec.funct3 = instruction.r.funct3;
        dec.funct7 = instruction.r.funct7;
        dec.rs1    = instruction.r.rs1;
        dec.rs2    = instruction.r.rs2;
        dec.rd     = instruction.r.rd;
        dec.zimm   = instruction.r.rs1;
        dec.csr    = instruction.i.imm_11_0;
        dec.shamt  = instruction.raw[25:20];
        dec.pred   = instruction.raw[27:24];
        dec.succ   = instruction.raw[23:20];

        // Class defaults, overridden by the opcode below
        dec.imm12      = 12'h000;
        dec.imm20      = 20'h00000;
        dec.fence      = 2'b00;
        dec.env        = 3'b000;
        dec.lui        = 1'b0;
        dec.auipc      = 1'b0;
        dec.jal        = 1'b0;
        dec.jalr       = 1'b0;
        dec.branching  = 1'b0;
        dec.processing = 1'b0;
        dec.inst_error = 1'b0;

        case (instruction.r.opcode)
            `RV_OP_LUI: begin
                dec.lui   = 1'b1;
                dec.imm20 = instruction.u.imm_31_12;
            end

            `RV_OP_AUIPC: begin
                dec.auipc = 1'b1;
                dec.imm20 = instruction.u.imm_31_12;
            end

            `RV_OP_JAL: begin
                dec.jal   = 1'b1;
                dec.imm20 = {instruction.j.imm_20,
                             instruction.j.imm_19_12,
                             instruction.j.imm_11,
                             instruction.j.imm_10_1};
            end

            `RV_OP_JALR: begin
                dec.jalr  = 1'b1;
                dec.imm12 = instruction.i.imm_11_0;
            end

            `RV_OP_BRANCH: begin
                dec.branching = 1'b1;
                dec.imm12     = {instruction.b.imm_12,
                                 instruction.b.imm_11,
                                 instruction.b.imm_10_5,
                                 instruction.b.imm_4_1};
            end

            `RV_OP_SYSTEM: begin
                if (instruction.i.funct3 != 3'b000) begin
                    dec.env = 3'b100;
                end else if (instruction.i.imm_11_0[0]) begin
                    dec.env = 3'b010;
                end else begin
                    dec.env = 3'b001;
                end
            end

            `RV_OP_FENCE: begin
                // funct3 bit 0 tells fence.i apart
                if (instruction.i.funct3[0]) begin
                    dec.fence = 2'b10;
                end else begin
                    dec.fence = 2'b01;
                end
            end

            `RV_OP_LOAD: begin
                dec.processing = 1'b1;
                dec.imm12      = instruction.i.imm_11_0;
            end

            `RV_OP_STORE: begin
                dec.processing = 1'b1;
                dec.imm12      = {instruction.s.imm_11_5, instruction.s.imm_4_0};
            end

            `RV_OP_IMM: begin
                dec.processing = 1'b1;
                dec.imm12      = instruction.i.imm_11_0;
            end

            `RV_OP_REG: begin
                dec.processing = 1'b1;
            end

            default: begin
                dec.inst_error = 1'b1;
            end
        endcase
    end

endmodule

// File: src/rv_fetch.sv
// PC, instruction memory handshake, JAL redirect and the single issue slot
`include "rv_consts.svh"

module rv_fetch (
    input  logic                  aclk,
    input  logic                  rst_n,
    output logic                  imem_req,
    output logic [`RV_XLEN-1:0]   imem_addr,
    input  logic                  imem_ack,
    input  logic [`RV_ILEN-1:0]   imem_rdata,
    output rv_pkg::rv_instr_u     instr,
    input  rv_pkg::rv_dec_t       dec,
    output logic                  issue_req,
    output rv_pkg::rv_issue_t     issue,
    input  logic                  issue_ack
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    logic                slot_free;
    logic                capture;

    assign instr     = imem_rdata;
    assign imem_addr = pc;

    // Slot is free once the previous issue handshake has fully closed
    assign slot_free = !issue_req && !issue_ack;
    assign capture   = imem_req && imem_ack && slot_free;

    // JAL offset is in halfwords
    assign next_pc = dec.jal ? pc + {{11{dec.imm20[19]}}, dec.imm20, 1'b0}
                             : pc + 32'd4;

    // Memory side
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            imem_req <= 1'b0;
            pc       <= `RV_RESET_PC;
        end else begin
            if (capture) begin
                imem_req <= 1'b0;
                pc       <= next_pc;
            end else if (!imem_req && !imem_ack) begin
                imem_req <= 1'b1;
            end
        end
    end

    // Issue side
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            issue_req <= 1'b0;
        end else begin
            if (capture) begin
                issue_req <= 1'b1;
            end else if (issue_req && issue_ack) begin
                issue_req <= 1'b0;
            end
        end
    end

    // Payload holds until the consumer has taken it
    always_ff @(posedge aclk) begin
        if (capture) begin
            issue.pc  <= pc;
            issue.dec <= dec;
        end
    end

endmodule

// File: src/rv_frontend.sv
// Top level of the instruction front end, fetch unit and decoder
`include "rv_consts.svh"

module rv_frontend (
    input  logic                  aclk,
    input  logic                  rst_n,
    // Instruction memory
    output logic                  imem_req,
    output logic [`RV_XLEN-1:0]   imem_addr,
    input  logic                  imem_ack,
    input  logic [`RV_ILEN-1:0]   imem_rdata,
    // Toward execution
    output logic                  issue_req,
    output rv_pkg::rv_issue_t     issue,
    input  logic                  issue_ack
);

    import rv_pkg::*;

    rv_instr_u instr;
    rv_dec_t   dec;

    rv_fetch fetch_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .instr      (instr),
        .dec        (dec),
        .issue_req  (issue_req),
        .issue      (issue),
        .issue_ack  (issue_ack)
    );

    rv_decoder decoder_i (
        .instruction (instr),
        .dec         (dec)
    );

endmodule

// File: tests/rv_frontend_assert.sv
// Handshake rules on the memory and issue ports, bound to rv_frontend
`include "rv_consts.svh"

module rv_frontend_assert (
    input logic                aclk,
    input logic                rst_n,
    input logic                imem_req,
    input logic [`RV_XLEN-1:0] imem_addr,
    input logic                imem_ack,
    input logic                issue_req,
    input rv_pkg::rv_issue_t   issue,
    input logic                issue_ack
);

    addr_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        imem_req |=> !imem_req || $stable(imem_addr))
        else $error("imem_addr changed while imem_req was high");

    issue_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        issue_req |=> !issue_req || $stable(issue))
        else $error("issue payload changed while issue_req was high");

    imem_req_held: assert property (@(posedge aclk) disable iff (!rst_n)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack");

    issue_req_held: assert property (@(posedge aclk) disable iff (!rst_n)
        issue_req && !issue_ack |=> issue_req)
        else $error("issue_req dropped before issue_ack");

    // Four-phase return to zero before a new request
    issue_req_quiet: assert property (@(posedge aclk) disable iff (!rst_n)
        !issue_req && issue_ack |=> !issue_req)
        else $error("issue_req rose while issue_ack was still high");

endmodule

bind rv_frontend rv_frontend_assert assert_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .issue_req (issue_req),
    .issue     (issue),
    .issue_ack (issue_ack)
);

// File: tests/rv_frontend_tb.sv
// Testbench for rv_frontend with memory and consumer models, reference decode,
// directed tests and a global cycle limit
`include "rv_consts.svh"

module rv_frontend_tb;

    import rv_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int ISSUE_BUDGET = 12;
    localparam int SLOW_ACK     = 20;
    localparam int N_ALU        = 8;
    localparam int N_UPPER      = 6;
    localparam int N_JAL        = 10;
    localparam int N_SYS        = 8;
    localparam int N_UNDEF      = 6;
    localparam int N_SLOW       = 16;
    localparam int TIMEOUT_CYCLES =
        (N_ALU + N_UPPER + N_JAL + N_SYS + N_UNDEF) * ISSUE_BUDGET
        + N_SLOW * (ISSUE_BUDGET + SLOW_ACK) + 7 * RESET_CYCLES;

    logic                aclk       = 1'b0;
    logic                rst_n      = 1'b0;
    logic                imem_req;
    logic [`RV_XLEN-1:0] imem_addr;
    logic                imem_ack   = 1'b0;
    logic [`RV_ILEN-1:0] imem_rdata = '0;
    logic                issue_req;
    rv_issue_t           issue;
    logic                issue_ack  = 1'b0;

    logic [31:0] mem [0:63];
    logic [31:0] mem_rng = 32'ha38c;
    logic [31:0] ack_rng = 32'ha38c;
    logic [1:0]  mem_cnt = 2'd0;
    int          ack_cnt = 0;
    int          max_ack = 2;
    int          cycle_count = 0;
    int          first_idx = 0;
    rv_issue_t   received [$];

    rv_frontend dut_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .issue_req  (issue_req),
        .issue      (issue),
        .issue_ack  (issue_ack)
    );

    initial begin
        forever #4 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return mem[addr[7:2]];
    endfunction

    // Decode straight from the RV32I encoding tables
    function automatic rv_dec_t ref_decode(input logic [31:0] w);
        rv_dec_t d;
        d        = '0;
        d.opcode = w[6:0];
        d.rd     = w[11:7];
        d.funct3 = w[14:12];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct7 = w[31:25];
        d.zimm   = w[19:15];
        d.csr    = w[31:20];
        d.shamt  = w[25:20];
        d.pred   = w[27:24];
        d.succ   = w[23:20];
        case (w[6:0])
            `RV_OP_LUI: begin
                d.lui   = 1'b1;
                d.imm20 = w[31:12];
            end
            `RV_OP_AUIPC: begin
                d.auipc = 1'b1;
                d.imm20 = w[31:12];
            end
            `RV_OP_JAL: begin
                d.jal   = 1'b1;
                d.imm20 = {w[31], w[19:12], w[20], w[30:21]};
            end
            `RV_OP_JALR: begin
                d.jalr  = 1'b1;
                d.imm12 = w[31:20];
            end
            `RV_OP_BRANCH: begin
                d.branching = 1'b1;
                d.imm12     = {w[31], w[7], w[30:25], w[11:8]};
            end
            `RV_OP_LOAD, `RV_OP_IMM: begin
                d.processing = 1'b1;
                d.imm12      = w[31:20];
            end
            `RV_OP_STORE: begin
                d.processing = 1'b1;
                d.imm12      = {w[31:25], w[11:7]};
            end
            `RV_OP_REG: begin
                d.processing = 1'b1;
            end
            `RV_OP_FENCE: begin
                d.fence = w[12] ? 2'b10 : 2'b01;
            end
            `RV_OP_SYSTEM: begin
                if (w[14:12] != 3'b000) begin
                    d.env = 3'b100;
                end else begin
                    d.env = w[20] ? 3'b010 : 3'b001;
                end
            end
            default: begin
                d.inst_error = 1'b1;
            end
        endcase
        return d;
    endfunction

    task automatic check_equal(input logic [159:0] got, input logic [159:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s (got %h, expected %h)", $time, msg, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Instruction memory with 0 to 3 cycles of latency per request
    always @(posedge aclk) begin
        if (!rst_n) begin
            imem_ack <= 1'b0;
            mem_cnt  <= 2'd0;
        end else if (imem_ack) begin
            if (!imem_req) begin
                imem_ack <= 1'b0;
            end
        end else if (imem_req) begin
            if (mem_cnt >= mem_rng[17:16]) begin
                imem_ack   <= 1'b1;
                imem_rdata <= word_at(imem_addr);
                mem_cnt    <= 2'd0;
                mem_rng    <= lcg_next(mem_rng);
            end else begin
                mem_cnt <= mem_cnt + 2'd1;
            end
        end
    end

    // Execution stage stand-in
    always @(posedge aclk) begin
        if (!rst_n) begin
            issue_ack <= 1'b0;
            ack_cnt   <= 0;
        end else if (issue_ack) begin
            if (!issue_req) begin
                issue_ack <= 1'b0;
            end
        end else if (issue_req) begin
            if (ack_cnt >= int'(ack_rng[23:16]) % (max_ack + 1)) begin
                issue_ack <= 1'b1;
                received.push_back(issue);
                ack_cnt   <= 0;
                ack_rng   <= lcg_next(ack_rng);
            end else begin
                ack_cnt <= ack_cnt + 1;
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run hung: issues still missing after %0d cycles", cycle_count);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // Every unused word is an ADDI whose immediate is its own address
    task automatic fill_memory();
        for (int k = 0; k < 64; k++) begin
            mem[k] = {4'h0, 6'(k), 2'b00, 20'h00013};
        end
    endtask

    task automatic restart();
        @(posedge aclk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
    endtask

    // Reset, wait for n issues and walk the program alongside them
    task automatic run_program(input int n);
        logic [31:0] pc;
        rv_dec_t     exp_dec;
        restart();
        first_idx = received.size();
        while (received.size() < first_idx + n) begin
            @(posedge aclk);
        end
        pc = `RV_RESET_PC;
        for (int k = 0; k < n; k++) begin
            exp_dec = ref_decode(word_at(pc));
            check_equal(160'(received[first_idx + k].pc), 160'(pc),
                        $sformatf("pc of issue %0d", k));
            check_equal(160'(received[first_idx + k].dec), 160'(exp_dec),
                        $sformatf("decoded record at pc %h", pc));
            if (exp_dec.jal) begin
                pc = pc + {{11{exp_dec.imm20[19]}}, exp_dec.imm20, 1'b0};
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic test_alu_mem();
        fill_memory();
        mem[0] = 32'h002081B3;  // add x3, x1, x2
        mem[1] = 32'h407302B3;  // sub x5, x6, x7
        mem[2] = 32'hFFB10093;  // addi x1, x2, -5
        mem[3] = 32'h0102A203;  // lw x4, 16(x5)
        mem[4] = 32'hFE63AA23;  // sw x6, -12(x7)
        run_program(N_ALU);
        check_equal(160'(received[first_idx + 4].dec.imm12), 160'(12'hFF4), "store imm12");
    endtask

    task automatic test_upper_branch();
        fill_memory();
        mem[0] = 32'h123452B7;  // lui x5, 0x12345
        mem[1] = 32'hABCDE317;  // auipc x6, 0xabcde
        mem[2] = 32'hFE208CE3;  // beq x1, x2, -8
        mem[3] = 32'h004100E7;  // jalr x1, 4(x2)
        run_program(N_UPPER);
        check_equal(160'(received[first_idx].dec.imm20), 160'(20'h12345), "lui imm20");
        check_equal(160'(received[first_idx + 2].dec.imm12), 160'(12'hFFC), "branch imm12");
    endtask

    task automatic test_jal();
        fill_memory();
        mem[0] = 32'h00700113;  // addi x2, x0, 7
        mem[1] = 32'h010000EF;  // jal x1, +16
        mem[6] = 32'hFF5FF06F;  // jal x0, -12
        run_program(N_JAL);
        check_equal(160'(received[first_idx + 2].pc), 160'(32'd20), "forward JAL target");
        check_equal(160'(received[first_idx + 4].pc), 160'(32'd12), "backward JAL target");
    endtask

    task automatic test_system_fence();
        fill_memory();
        mem[0] = 32'h00000073;  // ecall
        mem[1] = 32'h00100073;  // ebreak
        mem[2] = 32'h300110F3;  // csrrw x1, 0x300, x2
        mem[3] = 32'h3412D1F3;  // csrrwi x3, 0x341, 5
        mem[4] = 32'h0310000F;  // fence rw, w
        mem[5] = 32'h0000100F;  // fence.i
        run_program(N_SYS);
        check_equal(160'(received[first_idx + 1].dec.env), 160'(3'b010), "ebreak env");
        check_equal(160'(received[first_idx + 2].dec.csr), 160'(12'h300), "csr index");
        check_equal(160'(received[first_idx + 3].dec.zimm), 160'(5'd5), "csr zimm");
        check_equal(160'(received[first_idx + 4].dec.pred), 160'(4'h3), "fence pred");
        check_equal(160'(received[first_idx + 4].dec.succ), 160'(4'h1), "fence succ");
        check_equal(160'(received[first_idx + 5].dec.fence), 160'(2'b10), "fence.i code");
    endtask

    task automatic test_undefined();
        fill_memory();
        mem[0] = 32'hFFFFFFFF;
        mem[1] = 32'h00700113;  // addi x2, x0, 7
        mem[2] = 32'h0000002B;  // custom-1 opcode
        mem[3] = 32'h00700113;
        run_program(N_UNDEF);
        check_equal(160'(received[first_idx].dec.inst_error), 160'(1'b1), "inst_error flag");
        check_equal(160'(received[first_idx + 1].pc), 160'(32'd4), "pc after bad opcode");
    endtask

    task automatic test_backpressure();
        fill_memory();
        mem[0] = 32'h002081B3;
        mem[1] = 32'hFE63AA23;
        mem[2] = 32'hFE208CE3;
        mem[3] = 32'h123452B7;
        max_ack = SLOW_ACK;
        run_program(N_SLOW);
        max_ack = 2;
    endtask

    initial begin
        test_alu_mem();
        test_upper_branch();
        test_jal();
        test_system_fence();
        test_undefined();
        test_backpressure();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_fetch.sv
src/rv_frontend.sv
tests/rv_frontend_assert.sv
tests/rv_frontend_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the front end testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module rv_frontend_tb \
    -f vlog.f \
    -Mdir obj_dir -o rv_frontend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_frontend_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
